//--- files.f
hw/cpu_defs_pkg.sv
hw/isa_pkg.sv
hw/pc_reg.sv
hw/inst_fetch_port.sv
hw/if_id.sv
hw/id_decode.sv
hw/pipe_ctrl.sv
hw/fetch_front.sv
test/fetch_front_tb.sv

//--- hw/cpu_defs_pkg.sv
// shared widths, bubble value, reset vector and stall-vector layout of the front end
package cpu_defs_pkg;

    // datapath widths
    localparam int addr_w = 32;
    localparam int data_w = 32;

    // all-zero word, used as the pipeline bubble
    localparam logic [data_w-1:0] zero_word = '0;

    // first fetch address after reset (kseg1 boot vector)
    localparam logic [addr_w-1:0] reset_pc = 32'hbfc0_0000;

    // one stall bit per pipeline stage
    localparam int stall_w = 6;

    // bit positions inside the stall vector
    // a request from stage n sets bits 0..n
    localparam int st_pc  = 0;
    localparam int st_if  = 1;
    localparam int st_id  = 2;
    localparam int st_ex  = 3;
    localparam int st_mem = 4;
    localparam int st_wb  = 5;

endpackage

//--- hw/fetch_front.sv
// instruction front end top, pc, fetch port, if/id register, stall control and decode
`timescale 1ns/1ps

module fetch_front
    import cpu_defs_pkg::*;
#(
    parameter logic [addr_w-1:0] RESET_PC = reset_pc
)
(
    input  logic              clk,
    input  logic              rst,
    // instruction memory
    output logic              imem_req,
    output logic [addr_w-1:0] imem_addr,
    input  logic              imem_valid,
    input  logic [data_w-1:0] imem_rdata,
    // downstream control
    input  logic              ex_stall,
    input  logic              flush_in,
    input  logic              branch_flag,
    input  logic [addr_w-1:0] branch_target,
    output logic              branch_taken,
    // decoded stream
    output logic              dec_valid,
    output logic [addr_w-1:0] dec_pc,
    output logic [5:0]        dec_opcode,
    output logic [4:0]        dec_rs,
    output logic [4:0]        dec_rt,
    output logic [4:0]        dec_dst,
    output logic [data_w-1:0] dec_imm
);

    logic [addr_w-1:0]  pc;
    logic               pc_ready;
    logic               full;
    logic               inst_valid;
    logic [addr_w-1:0]  if_pc;
    logic [data_w-1:0]  if_inst;
    logic [addr_w-1:0]  id_pc;
    logic [data_w-1:0]  id_inst;
    logic               stallreq_for_if;
    logic               stallreq_for_ex;
    logic [stall_w-1:0] stall;
    logic               flush;

    pc_reg #(
        .RESET_PC (RESET_PC)
    ) i_pc_reg (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .pc_ready      (pc_ready),
        .branch_flag   (branch_flag),
        .branch_target (branch_target),
        .pc            (pc),
        .branch_taken  (branch_taken)
    );

    inst_fetch_port i_inst_fetch_port (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .full       (full),
        .flush      (flush),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_valid (imem_valid),
        .imem_rdata (imem_rdata),
        .inst_valid (inst_valid),
        .if_pc      (if_pc),
        .if_inst    (if_inst),
        .pc_ready   (pc_ready)
    );

    if_id i_if_id (
        .clk             (clk),
        .rst             (rst),
        .if_pc           (if_pc),
        .if_inst         (if_inst),
        .flush           (flush),
        .stall           (stall),
        .inst_valid      (inst_valid),
        .pc_ready        (pc_ready),
        .branch_flag     (branch_flag),
        .id_pc           (id_pc),
        .id_inst         (id_inst),
        .stallreq_for_if (stallreq_for_if),
        .stallreq_for_ex (stallreq_for_ex),
        .full            (full)
    );

    pipe_ctrl i_pipe_ctrl (
        .rst             (rst),
        .stallreq_for_if (stallreq_for_if),
        .stallreq_for_ex (stallreq_for_ex),
        .ex_stall        (ex_stall),
        .flush_in        (flush_in),
        .stall           (stall),
        .flush           (flush)
    );

    id_decode i_id_decode (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .flush      (flush),
        .id_pc      (id_pc),
        .id_inst    (id_inst),
        .dec_valid  (dec_valid),
        .dec_pc     (dec_pc),
        .dec_opcode (dec_opcode),
        .dec_rs     (dec_rs),
        .dec_rt     (dec_rt),
        .dec_dst    (dec_dst),
        .dec_imm    (dec_imm)
    );

endmodule

//--- hw/id_decode.sv
// decode-stage register, splits the held word into R-type or I-type fields
`timescale 1ns/1ps

module id_decode
    import cpu_defs_pkg::*;
    import isa_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic [stall_w-1:0] stall,
    input  logic               flush,
    input  logic [addr_w-1:0]  id_pc,
    input  logic [data_w-1:0]  id_inst,
    output logic               dec_valid,
    output logic [addr_w-1:0]  dec_pc,
    output logic [5:0]         dec_opcode,
    output logic [4:0]         dec_rs,
    output logic [4:0]         dec_rt,
    output logic [4:0]         dec_dst,
    output logic [data_w-1:0]  dec_imm
);

    inst_u             word;
    logic              is_rtype;
    logic [4:0]        dst_next;
    logic [data_w-1:0] imm_next;
    logic              advance;

    assign word = id_inst;

    // opcode and rs/rt sit in the same place in both views
    assign is_rtype = (word.r.opcode == op_special);

    // R-type writes rd, everything else writes rt
    assign dst_next = is_rtype ? word.r.rd : word.i.rt;

    // sign-extended imm16, nothing for R-type
    assign imm_next = is_rtype ? zero_word : {{(data_w-16){word.i.imm16[15]}}, word.i.imm16};

    // hold everything while decode is stalled
    assign advance = !stall[st_id];

    always_ff @(posedge clk)
    begin
        if (rst || flush)
            dec_valid <= 1'b0;
        else if (advance)
            dec_valid <= (id_inst != zero_word);
    end

    // decoded fields
    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            dec_pc     <= id_pc;
            dec_opcode <= word.i.opcode;
            dec_rs     <= word.i.rs;
            dec_rt     <= word.i.rt;
            dec_dst    <= dst_next;
            dec_imm    <= imm_next;
        end
    end

endmodule

//--- hw/if_id.sv
// fetch/decode pipeline register with one-entry save slot and stall requests
`timescale 1ns/1ps

module if_id
    import cpu_defs_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic [addr_w-1:0]  if_pc,
    input  logic [data_w-1:0]  if_inst,
    input  logic               flush,
    input  logic [stall_w-1:0] stall,
    input  logic               inst_valid,
    input  logic               pc_ready,
    input  logic               branch_flag,
    output logic [addr_w-1:0]  id_pc,
    output logic [data_w-1:0]  id_inst,
    output logic               stallreq_for_if,
    output logic               stallreq_for_ex,
    output logic               full
);

    logic [addr_w-1:0] if_pc_filtered;
    logic [data_w-1:0] if_inst_filtered;
    // save slot, holds one word that arrived under a decode stall
    logic              saved;
    logic [addr_w-1:0] saved_pc;
    logic [data_w-1:0] saved_inst;
    logic              park;

    // fetch outputs only mean something with inst_valid
    assign if_pc_filtered   = inst_valid ? if_pc : zero_word;
    assign if_inst_filtered = inst_valid ? if_inst : zero_word;

    // word arriving while decode cannot take it
    assign park = inst_valid && stall[st_id];

    // fetch holds off new reads while the slot is occupied
    assign full = saved;

    // nothing arriving, nothing parked, nothing for the pc to do
    assign stallreq_for_if = !(inst_valid || saved || pc_ready);

    // branch waits until the pc can take it
    assign stallreq_for_ex = branch_flag && !pc_ready;

    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            id_pc   <= zero_word;
            id_inst <= zero_word;
        end
        else if (!stall[st_if])
        begin
            // parked word goes first, it is older than anything new
            if (saved)
            begin
                id_pc   <= saved_pc;
                id_inst <= saved_inst;
            end
            else
            begin
                id_pc   <= if_pc_filtered;
                id_inst <= if_inst_filtered;
            end
        end
        else if (!stall[st_id])
        begin
            // fetch stalled, decode moves on, so feed a bubble
            id_pc   <= zero_word;
            id_inst <= zero_word;
        end
        // both stalled, hold
    end

    // slot occupancy
    always_ff @(posedge clk)
    begin
        if (rst || flush)
            saved <= 1'b0;
        else if (park)
            saved <= 1'b1;
        else if (!stall[st_id])
            saved <= 1'b0;
    end

    // slot payload
    always_ff @(posedge clk)
    begin
        if (park)
        begin
            saved_pc   <= if_pc;
            saved_inst <= if_inst;
        end
    end

endmodule

//--- hw/inst_fetch_port.sv
// instruction memory port, one read in flight, returns each word with its address
`timescale 1ns/1ps

module inst_fetch_port
    import cpu_defs_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [addr_w-1:0] pc,
    input  logic              full,
    input  logic              flush,
    output logic              imem_req,
    output logic [addr_w-1:0] imem_addr,
    input  logic              imem_valid,
    input  logic [data_w-1:0] imem_rdata,
    output logic              inst_valid,
    output logic [addr_w-1:0] if_pc,
    output logic [data_w-1:0] if_inst,
    output logic              pc_ready
);

    // fsm encoding
    localparam logic s_idle = 1'b0;
    localparam logic s_wait = 1'b1;

    logic              state;
    logic [addr_w-1:0] addr_q;
    // flush seen while the read was outstanding
    logic              drop_q;
    // a dropped word still owes the pc its step
    logic              drop_hold;
    logic              done;
    logic              drop_now;
    logic              issue;

    assign done     = (state == s_wait) && imem_valid;
    assign drop_now = drop_q || flush;

    // pc may advance when a word returns, while a word sits in the
    // if_id save slot, or after a dropped word until pc moves on
    assign pc_ready = done || full || (drop_hold && (pc == addr_q));

    // new read only when nothing is owed to the pc
    assign issue = (state == s_idle) && !pc_ready && !flush;

    // address stays stable for the whole read
    assign imem_req  = (state == s_wait);
    assign imem_addr = addr_q;

    // wrong-path words never reach if_id
    assign inst_valid = done && !drop_now;
    assign if_pc      = addr_q;
    assign if_inst    = imem_rdata;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= s_idle;
            drop_q    <= 1'b0;
            drop_hold <= 1'b0;
        end
        else if (state == s_idle)
        begin
            if (issue)
                state <= s_wait;
            // pc has moved past the dropped address
            if (drop_hold && (pc != addr_q))
                drop_hold <= 1'b0;
        end
        else
        begin
            if (flush)
                drop_q <= 1'b1;
            if (done)
            begin
                state     <= s_idle;
                drop_q    <= 1'b0;
                drop_hold <= drop_now;
            end
        end
    end

    // latch the address at issue
    always_ff @(posedge clk)
    begin
        if (issue)
            addr_q <= pc;
    end

endmodule

//--- hw/isa_pkg.sv
// opcode values and the two-view instruction word of the MIPS-style ISA
package isa_pkg;

    // primary opcodes, bits 31:26
    localparam logic [5:0] op_special = 6'b000000;
    localparam logic [5:0] op_addiu   = 6'b001001;
    localparam logic [5:0] op_lw      = 6'b100011;
    localparam logic [5:0] op_sw      = 6'b101011;
    localparam logic [5:0] op_beq     = 6'b000100;

    // one 32-bit word, decoded either as R-type or as I-type
    // both views share opcode, rs and rt at the same bit positions
    typedef union packed {
        // register format, function selected by funct
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        // immediate format, loads, stores, branches, alu-immediate
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm16;
        } i;
    } inst_u;

endpackage

//--- hw/pc_reg.sv
// program counter, steps by four per fetched word or loads a pending branch target
`timescale 1ns/1ps

module pc_reg
    import cpu_defs_pkg::*;
#(
    parameter logic [addr_w-1:0] RESET_PC = reset_pc
)
(
    input  logic               clk,
    input  logic               rst,
    input  logic [stall_w-1:0] stall,
    input  logic               pc_ready,
    input  logic               branch_flag,
    input  logic [addr_w-1:0]  branch_target,
    output logic [addr_w-1:0]  pc,
    output logic               branch_taken
);

    logic step;
    logic branch_pending;

    // requester holds branch_flag until it sees branch_taken,
    // so ignore it during the taken cycle to avoid a second load
    assign branch_pending = branch_flag && !branch_taken;

    // fetch is done with the current address and stage 0 may move
    assign step = pc_ready && !stall[st_pc];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc           <= RESET_PC;
            branch_taken <= 1'b0;
        end
        else
        begin
            // one-cycle pulse when the target is absorbed
            branch_taken <= step && branch_pending;
            if (step)
            begin
                if (branch_pending)
                    pc <= branch_target;
                else
                    pc <= pc + addr_w'(4);
            end
        end
    end

endmodule

//--- hw/pipe_ctrl.sv
// stall controller, builds the stall vector from stage requests and forwards flush
`timescale 1ns/1ps

module pipe_ctrl
    import cpu_defs_pkg::*;
(
    input  logic               rst,
    input  logic               stallreq_for_if,
    input  logic               stallreq_for_ex,
    input  logic               ex_stall,
    input  logic               flush_in,
    output logic [stall_w-1:0] stall,
    output logic               flush
);

    // stall bits 0 up to and including the requesting stage
    function automatic logic [stall_w-1:0] stall_upto(input int stage);
        logic [stall_w-1:0] mask;
        mask = '0;
        for (int i = 0; i <= stage; i++)
            mask[i] = 1'b1;
        return mask;
    endfunction

    always_comb
    begin
        // flush wins over every request
        if (rst || flush_in)
            stall = '0;
        // later stage first, it covers the earlier one
        else if (stallreq_for_ex || ex_stall)
            stall = stall_upto(st_ex);
        else if (stallreq_for_if)
            stall = stall_upto(st_if);
        else
            stall = '0;
    end

    // flush passes straight through
    assign flush = flush_in;

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the fetch front end testbench with verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -f files.f --top-module fetch_front_tb -o fetch_front_sim &&
./obj_dir/fetch_front_sim | tee /dev/stderr | grep "^all tests passed$" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- test/fetch_front_golden.mem
// @00 header: program words, expected count, branch src, target, flush addr,
//     stall0 dec pc, length, stall1 dec pc, length; @10 program; @30 expected pcs
@00
00000018 00000012 bfc00018 bfc00030 bfc00040
bfc00008 00000006 bfc00048 00000005
@10
24010005 2402fffc 00221821 8c640010 ac640014 00852023 10220008 24050001
24060002 24070003 24080004 24090005 240a8000 014b6025 8d4d0000 25ad0001
240effff 01cf7821 ad8f0008 8dd0fff8 02118824 2631007f 1231fffe 00009025
@30
bfc00000 bfc00004 bfc00008 bfc0000c bfc00010 bfc00014 bfc00018
bfc00030 bfc00034 bfc00038 bfc0003c
bfc00044 bfc00048 bfc0004c bfc00050 bfc00054 bfc00058 bfc0005c

//--- test/fetch_front_tb.sv
// testbench for the fetch front end, plays instruction memory and later stages
`timescale 1ns/1ps

module fetch_front_tb;

    localparam logic [31:0] tb_reset_pc = 32'hbfc0_0000;

    logic        clk;
    logic        rst;
    logic        imem_req;
    logic [31:0] imem_addr;
    logic        imem_valid;
    logic [31:0] imem_rdata;
    logic        ex_stall;
    logic        flush_in;
    logic        branch_flag;
    logic [31:0] branch_target;
    logic        branch_taken;
    logic        dec_valid;
    logic [31:0] dec_pc;
    logic [5:0]  dec_opcode;
    logic [4:0]  dec_rs;
    logic [4:0]  dec_rt;
    logic [4:0]  dec_dst;
    logic [31:0] dec_imm;

    // golden image, header at 0, program at 16, expected pcs at 48
    logic [31:0] gold [0:127];
    int          n_prog;
    int          n_exp;
    int          idx;
    int          errors;
    int          checks;
    // memory model state
    logic [31:0] lfsr;
    logic        busy;
    int          wait_cnt;
    logic [31:0] req_addr;
    // scheduled events
    logic        br_done;
    logic        fl_done;
    logic        taken_seen;
    logic        st0_done;
    logic        st1_done;
    int          stall_arm;
    int          stall_left;
    // decode outputs seen at the previous falling edge
    logic        prev_hold;
    logic        prev_valid;
    logic [31:0] prev_pc;
    logic [5:0]  prev_opcode;
    logic [4:0]  prev_rs;
    logic [4:0]  prev_rt;
    logic [4:0]  prev_dst;
    logic [31:0] prev_imm;

    fetch_front #(
        .RESET_PC (tb_reset_pc)
    ) i_fetch_front (
        .clk           (clk),
        .rst           (rst),
        .imem_req      (imem_req),
        .imem_addr     (imem_addr),
        .imem_valid    (imem_valid),
        .imem_rdata    (imem_rdata),
        .ex_stall      (ex_stall),
        .flush_in      (flush_in),
        .branch_flag   (branch_flag),
        .branch_target (branch_target),
        .branch_taken  (branch_taken),
        .dec_valid     (dec_valid),
        .dec_pc        (dec_pc),
        .dec_opcode    (dec_opcode),
        .dec_rs        (dec_rs),
        .dec_rt        (dec_rt),
        .dec_dst       (dec_dst),
        .dec_imm       (dec_imm)
    );

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 32'h8020_0003;
        return n;
    endfunction

    // program word at an address, outside the program an address-wide fill
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] off;
        int          k;
        off = addr - tb_reset_pc;
        k = int'(off >> 2);
        if (addr[1:0] == 2'b00 && off < 32'd128 && k < n_prog)
            return gold[16 + k];
        return ~addr;
    endfunction

    // compare a newly decoded word against the golden pc and the field rule
    task automatic check_entry(input int k);
        logic [31:0] w;
        logic [4:0]  exp_dst;
        logic [31:0] exp_imm;
        w = mem_word(gold[48 + k]);
        // rd for special, rt otherwise, imm16 sign-extended only for i-type
        if (w[31:26] == 6'b000000)
        begin
            exp_dst = w[15:11];
            exp_imm = 32'h0;
        end
        else
        begin
            exp_dst = w[20:16];
            exp_imm = {{16{w[15]}}, w[15:0]};
        end
        checks = checks + 1;
        assert (dec_pc == gold[48 + k])
        else
        begin
            errors = errors + 1;
            $display("Fail at %0t: entry %0d pc %h, expected %h", $time, k, dec_pc,
                     gold[48 + k]);
        end
        assert (dec_opcode == w[31:26] && dec_rs == w[25:21] && dec_rt == w[20:16])
        else
        begin
            errors = errors + 1;
            $display("Fail at %0t: pc %h opcode/rs/rt mismatch", $time, dec_pc);
        end
        assert (dec_dst == exp_dst && dec_imm == exp_imm)
        else
        begin
            errors = errors + 1;
            $display("Fail at %0t: pc %h dst %0d imm %h, expected %0d %h", $time, dec_pc,
                     dec_dst, dec_imm, exp_dst, exp_imm);
        end
    endtask

    // one drive step, 1 ns after the rising edge
    task automatic drive_cycle();
        logic [1:0] bits;
        imem_valid = 1'b0;
        flush_in   = 1'b0;
        if (branch_flag && branch_taken)
        begin
            branch_flag = 1'b0;
            taken_seen  = 1'b1;
        end
        if (stall_arm > 0)
        begin
            stall_left = stall_arm;
            stall_arm  = 0;
        end
        // park the pipe once every expected word is decoded
        ex_stall = (stall_left > 0) || (idx >= n_exp);
        if (stall_left > 0)
            stall_left = stall_left - 1;
        if (busy)
        begin
            // request level and address held until the answer
            checks = checks + 1;
            assert (imem_req && imem_addr == req_addr)
            else
            begin
                errors = errors + 1;
                $display("Fail at %0t: read moved before answer, req %b addr %h, expected %h",
                         $time, imem_req, imem_addr, req_addr);
            end
            if (wait_cnt == 1)
            begin
                imem_valid = 1'b1;
                imem_rdata = mem_word(imem_addr);
                busy       = 1'b0;
                // branch absorbed together with the in-flight word
                if (imem_addr == gold[2] && !br_done)
                begin
                    branch_flag   = 1'b1;
                    branch_target = gold[3];
                    br_done       = 1'b1;
                end
                // flush drops the in-flight word
                if (imem_addr == gold[4] && !fl_done)
                begin
                    flush_in = 1'b1;
                    fl_done  = 1'b1;
                end
            end
            else
                wait_cnt = wait_cnt - 1;
        end
        else if (imem_req)
        begin
            bits[0]  = lfsr[0];
            lfsr     = lfsr_next(lfsr);
            bits[1]  = lfsr[0];
            lfsr     = lfsr_next(lfsr);
            busy     = 1'b1;
            req_addr = imem_addr;
            wait_cnt = int'(bits) + 1;
        end
    endtask

    // sample decode outputs at the falling edge
    task automatic monitor_cycle();
        if (prev_hold)
        begin
            checks = checks + 1;
            assert (dec_valid == prev_valid && dec_pc == prev_pc && dec_opcode == prev_opcode
                    && dec_rs == prev_rs && dec_rt == prev_rt && dec_dst == prev_dst
                    && dec_imm == prev_imm)
            else
            begin
                errors = errors + 1;
                $display("Fail at %0t: decode outputs moved under ex_stall", $time);
            end
        end
        if (dec_valid && (!prev_valid || dec_pc != prev_pc))
        begin
            if (idx < n_exp)
                check_entry(idx);
            idx = idx + 1;
            if (dec_pc == gold[5] && !st0_done)
            begin
                stall_arm = int'(gold[6]);
                st0_done  = 1'b1;
            end
            if (dec_pc == gold[7] && !st1_done)
            begin
                stall_arm = int'(gold[8]);
                st1_done  = 1'b1;
            end
        end
        // ex_stall now is the value seen at the next edge
        prev_hold   = ex_stall && !flush_in;
        prev_valid  = dec_valid;
        prev_pc     = dec_pc;
        prev_opcode = dec_opcode;
        prev_rs     = dec_rs;
        prev_rt     = dec_rt;
        prev_dst    = dec_dst;
        prev_imm    = dec_imm;
    endtask

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    // stimulus
    initial
    begin
        rst           = 1'b1;
        imem_valid    = 1'b0;
        imem_rdata    = 32'h0;
        ex_stall      = 1'b0;
        flush_in      = 1'b0;
        branch_flag   = 1'b0;
        branch_target = 32'h0;
        lfsr          = 32'h89f3_9019;
        busy          = 1'b0;
        wait_cnt      = 0;
        req_addr      = 32'h0;
        br_done       = 1'b0;
        fl_done       = 1'b0;
        taken_seen    = 1'b0;
        st0_done      = 1'b0;
        st1_done      = 1'b0;
        stall_arm     = 0;
        stall_left    = 0;
        idx           = 0;
        errors        = 0;
        checks        = 0;
        prev_hold     = 1'b0;
        prev_valid    = 1'b0;
        $readmemh("test/fetch_front_golden.mem", gold);
        n_prog = int'(gold[0]);
        n_exp  = int'(gold[1]);
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        forever
        begin
            @(posedge clk);
            #1 drive_cycle();
        end
    end

    initial
    begin
        @(negedge rst);
        forever
        begin
            @(negedge clk);
            monitor_cycle();
        end
    end

    // end of run once every expected word is decoded
    initial
    begin
        #1;
        wait (idx >= n_exp);
        repeat (10) @(posedge clk);
        checks = checks + 1;
        assert (br_done && fl_done && taken_seen && idx == n_exp)
        else
        begin
            errors = errors + 1;
            $display("scheduled branch or flush never happened, or extra words were decoded");
        end
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    // watchdog, 40 cycles per expected word
    initial
    begin
        #1;
        repeat (n_exp * 40 + 20) @(posedge clk);
        $display("run timed out after %0d of %0d decoded words", idx, n_exp);
        $display("tests failed");
        $finish;
    end

endmodule
